// ==== all.f ====
rtl/bridge_pkg.sv
rtl/panel_pkg.sv
rtl/tick_gen.sv
rtl/i2c_line_bridge.sv
rtl/eink_relay.sv
rtl/shutdown_fuze.sv
rtl/esp32_bridge_top.sv
test/tb_clock.sv
test/bridge_assert.sv
test/tb_top.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module tb_top -f all.f
	out=$$(./obj_dir/Vtb_top); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only -Wall --top-module esp32_bridge_top \
		rtl/bridge_pkg.sv rtl/panel_pkg.sv rtl/tick_gen.sv rtl/i2c_line_bridge.sv \
		rtl/eink_relay.sv rtl/shutdown_fuze.sv rtl/esp32_bridge_top.sv

clean:
	rm -rf obj_dir

// ==== test/tb_top.sv ====
`timescale 1ns/1ns

module tb_top
    import panel_pkg::*;
();

    localparam int DIV_BITS    = 3;
    localparam int FUZE_COUNT  = 8;
    localparam int LAT_MAX     = 2 + 2 * (1 + 2 ** DIV_BITS); // bridge worst case in clocks
    localparam int CYCLE_LIMIT = 4000;                        // roughly twice the full run

    logic clk, arst_n;
    logic scl_a, sda_a, scl_a_low, sda_a_low;
    logic scl_b, sda_b, scl_b_low, sda_b_low;
    logic esp_dc, esp_sdi, esp_cs, esp_clk, esp_busy;
    logic pnl_dc, pnl_sdi, pnl_cs, pnl_clk, pnl_busy;
    logic host_txd, host_rxd, esp_txd, esp_rxd;
    logic shutdown;
    logic agent_scl_a, agent_sda_a, agent_scl_b, agent_sda_b; // 1 = released

    int          errors = 0;      // directed checks
    int          checks = 0;
    int          cmp_errors = 0;  // comparing process
    int          cmp_checks = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'heff3;
    logic [4:0]  prev_in = '0;    // relay inputs seen one cycle back
    string       out_names [0:6] = '{"host_rxd", "esp_rxd", "esp_busy", "pnl_clk",
                                     "pnl_cs", "pnl_sdi", "pnl_dc"};

    tb_clock u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    esp32_bridge_top #(
        .DIV_BITS   (DIV_BITS),
        .FUZE_COUNT (FUZE_COUNT)
    ) u_dut (.*);

    bind i2c_line_bridge bridge_assert u_assert (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick),
        .a_low  (a_low),
        .b_low  (b_low),
        .state  (state)
    );

    // wired-AND on the board with agent and DUT both open drain
    assign scl_a = agent_scl_a & ~scl_a_low;
    assign sda_a = agent_sda_a & ~sda_a_low;
    assign scl_b = agent_scl_b & ~scl_b_low;
    assign sda_b = agent_sda_b & ~sda_b_low;

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    function automatic logic next_random_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);    // one step per bit
        return b;
    endfunction

    // relay is one register late and the console has no delay
    function automatic logic [6:0] expect_outputs(input logic [4:0] last_in,
                                                  input logic txd_host, input logic txd_esp);
        return {last_in, txd_host, txd_esp};
    endfunction

    // line 0 is scl and line 1 sda
    // side 0 is esp32 and side 1 hdmi
    function automatic logic enable_of(input int line, input int side);
        if (line == 0)
            return (side == 0) ? scl_a_low : scl_b_low;
        return (side == 0) ? sda_a_low : sda_b_low;
    endfunction

    function automatic string enable_name(input int line, input int side);
        if (line == 0)
            return (side == 0) ? "scl_a_low" : "scl_b_low";
        return (side == 0) ? "sda_a_low" : "sda_b_low";
    endfunction

    task automatic set_agent(input int line, input int side, input logic level);
        case ({line == 1, side == 1})
            2'b00:   agent_scl_a = level;
            2'b01:   agent_scl_b = level;
            2'b10:   agent_sda_a = level;
            default: agent_sda_b = level;
        endcase
    endtask

    task automatic check_value(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("error %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic report_counts();
        $display("compare checks %0d errors %0d, directed checks %0d errors %0d",
                 cmp_checks, cmp_errors, checks, errors);
    endtask

    // the side that drives low must never be pulled meanwhile
    task automatic await_enable(input int line, input int side, input logic level);
        int n;
        n = 0;
        while (enable_of(line, side) !== level && n < LAT_MAX)
        begin
            @(negedge clk);
            n++;
            check_value(enable_name(line, 1 - side), 1'b0, enable_of(line, 1 - side));
        end
        if (enable_of(line, side) !== level)
        begin
            errors++;
            $display("%s did not reach %b within %0d cycles",
                     enable_name(line, side), level, LAT_MAX);
        end
    endtask

    task automatic line_pass(input int line, input int drv);
        @(posedge clk);
        #1 set_agent(line, drv, 1'b0);
        await_enable(line, 1 - drv, 1'b1);
        repeat (10)                       // far side follows while held low
        begin
            @(negedge clk);
            check_value(enable_name(line, 1 - drv), 1'b1, enable_of(line, 1 - drv));
            check_value(enable_name(line, drv), 1'b0, enable_of(line, drv));
        end
        @(posedge clk);
        #1 set_agent(line, drv, 1'b1);
        await_enable(line, 1 - drv, 1'b0);
        repeat (40)                       // both idle high with no latch-up
        begin
            @(negedge clk);
            check_value(enable_name(line, 0), 1'b0, enable_of(line, 0));
            check_value(enable_name(line, 1), 1'b0, enable_of(line, 1));
        end
    endtask

    // one bus phase from side a with b sampled mid phase
    task automatic send_phase(input logic scl_v, input logic sda_v);
        @(posedge clk);
        #1 agent_scl_a = scl_v;
        agent_sda_a = sda_v;
        repeat (20) @(negedge clk);
        check_value("scl_b", scl_v, scl_b);
        check_value("sda_b", sda_v, sda_b);
        repeat (19) @(negedge clk);
    endtask

    task automatic send_byte_a();
        logic b;
        send_phase(1'b1, 1'b0);           // start
        for (int i = 0; i < 8; i++)
        begin
            b = next_random_bit();
            send_phase(1'b0, b);          // data set while scl low
            send_phase(1'b1, b);
        end
        send_phase(1'b0, 1'b0);           // ack
        send_phase(1'b1, 1'b0);
        send_phase(1'b0, 1'b0);           // stop
        send_phase(1'b1, 1'b0);
        send_phase(1'b1, 1'b1);
    endtask

    task automatic dc_falls(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1 esp_dc = 1'b1;
            @(posedge clk);
            #1 esp_dc = 1'b0;
        end
    endtask

    task automatic fuze_test();
        int          n;
        fuze_state_t fst;
        @(posedge clk);
        #1 esp_cs = 1'b1;
        esp_dc = 1'b0;
        repeat (3) @(posedge clk);        // fuze into COUNTING
        dc_falls(FUZE_COUNT - 1);         // one short
        repeat (5) @(negedge clk);
        check_value("shutdown", 1'b0, shutdown);
        @(posedge clk);
        #1 esp_cs = 1'b0;                 // break the gesture
        repeat (3) @(posedge clk);
        #1 esp_cs = 1'b1;
        repeat (3) @(posedge clk);
        dc_falls(FUZE_COUNT);
        n = 0;
        while (shutdown !== 1'b1 && n < 3)
        begin
            @(negedge clk);
            n++;
        end
        if (shutdown !== 1'b1)
        begin
            errors++;
            fst = u_dut.u_fuze.state;
            $display("shutdown did not rise after the last dc fall, fuze in %s", fst.name());
        end
        @(posedge clk);
        #1 esp_cs = 1'b0;
        esp_dc = 1'b0;
        repeat (20)                       // sticky until reset
        begin
            @(negedge clk);
            check_value("shutdown", 1'b1, shutdown);
        end
    endtask

    // relay and console against the reference on every cycle
    always @(negedge clk)
    begin : compare_outputs
        logic [6:0] exp_out;
        logic [6:0] got_out;
        exp_out = expect_outputs(prev_in, host_txd, esp_txd);
        got_out = {pnl_dc, pnl_sdi, pnl_cs, pnl_clk, esp_busy, esp_rxd, host_rxd};
        if (arst_n === 1'b1)              // compare once out of reset
        begin
            for (int k = 0; k < 7; k++)
            begin
                cmp_checks++;
                if (got_out[k] !== exp_out[k])
                begin
                    cmp_errors++;
                    $display("error %0t %s expected %b actual %b",
                             $time, out_names[k], exp_out[k], got_out[k]);
                end
            end
        end
        prev_in = arst_n ? {esp_dc, esp_sdi, esp_cs, esp_clk, pnl_busy} : 5'b0;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("run stopped after %0d cycles before the tests completed", cycles);
            report_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial
    begin : stimulus
        logic [6:0] r;
        agent_scl_a = 1'b1;
        agent_sda_a = 1'b1;
        agent_scl_b = 1'b1;
        agent_sda_b = 1'b1;
        {esp_dc, esp_sdi, esp_cs, esp_clk, pnl_busy} = '0;
        host_txd = 1'b1;                  // uart idle high
        esp_txd  = 1'b1;
        wait (arst_n === 1'b1);
        @(negedge clk);
        check_value("scl_a_low", 1'b0, scl_a_low);
        check_value("sda_a_low", 1'b0, sda_a_low);
        check_value("scl_b_low", 1'b0, scl_b_low);
        check_value("sda_b_low", 1'b0, sda_b_low);
        check_value("shutdown", 1'b0, shutdown);
        repeat (200)                      // random relay and console traffic
        begin
            @(posedge clk);
            for (int k = 0; k < 7; k++)
                r[k] = next_random_bit();
            #1 {esp_dc, esp_sdi, esp_cs, esp_clk, pnl_busy, host_txd, esp_txd} = r;
        end
        @(posedge clk);
        #1 {esp_dc, esp_sdi, esp_cs, esp_clk, pnl_busy} = '0;
        host_txd = 1'b1;
        esp_txd  = 1'b1;
        line_pass(0, 0);                  // scl from a to b
        line_pass(1, 0);                  // sda from a to b
        line_pass(0, 1);                  // scl from b to a
        line_pass(1, 1);
        send_byte_a();
        fuze_test();
        report_counts();
        if (errors == 0 && cmp_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== test/bridge_assert.sv ====
`timescale 1ns/1ns

module bridge_assert
    import bridge_pkg::*;
(
    input logic          clk,
    input logic          arst_n,
    input logic          tick,
    input logic          a_low,
    input logic          b_low,
    input bridge_state_t state
);

    // a bridge never pulls both sides of its line
    double_pull_chk: assert property (@(posedge clk) disable iff (!arst_n)
        !(a_low && b_low))
        else $error("a_low and b_low high together");

    // enables follow the state, state only moves on tick
    a_rise_chk: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(a_low) |-> $past(tick))
        else $error("a_low rose without a tick before it");

    b_rise_chk: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(b_low) |-> $past(tick))
        else $error("b_low rose without a tick before it");

    // guard tick, both sides let go
    release_chk: assert property (@(posedge clk) disable iff (!arst_n)
        (state == RELEASE) |-> (!a_low && !b_low))
        else $error("enable high in RELEASE");

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk    = 1'b0;
        arst_n = 1'b0;              // in reset from time zero
        repeat (2) @(posedge clk);  // two full cycles
        #1 arst_n = 1'b1;           // released off the edge
    end

    always #4 clk = ~clk;           // 8 ns period

endmodule

// ==== rtl/esp32_bridge_top.sv ====
`timescale 1ns/1ns

module esp32_bridge_top
    import panel_pkg::*;
#(
    parameter int DIV_BITS   = 3, // bridge sample tick every 9 clocks
    parameter int FUZE_COUNT = 8  // dc falls that power off
)
(
    input  logic clk,
    input  logic arst_n,

    // esp32 side open-drain i2c
    input  logic scl_a,
    input  logic sda_a,
    output logic scl_a_low,
    output logic sda_a_low,

    // hdmi ddc side open-drain i2c
    input  logic scl_b,
    input  logic sda_b,
    output logic scl_b_low,
    output logic sda_b_low,

    // e-paper spi, esp32 side
    input  logic esp_dc,
    input  logic esp_sdi,
    input  logic esp_cs,
    input  logic esp_clk,
    output logic esp_busy,

    // e-paper spi, panel side
    output logic pnl_dc,
    output logic pnl_sdi,
    output logic pnl_cs,
    output logic pnl_clk,
    input  logic pnl_busy,

    // usb-serial console
    input  logic host_txd,
    output logic host_rxd,
    input  logic esp_txd,
    output logic esp_rxd,

    output logic shutdown   // power-off request
);

    logic     tick;
    spi_bus_t esp_bus;
    spi_bus_t pnl_bus;
    logic     dc_q;
    logic     cs_q;

    tick_gen #(
        .DIV_BITS (DIV_BITS)
    ) u_tick (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick)
    );

    // one bridge per i2c line, same tick
    i2c_line_bridge u_scl (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick),
        .a_in   (scl_a),
        .b_in   (scl_b),
        .a_low  (scl_a_low),
        .b_low  (scl_b_low)
    );

    i2c_line_bridge u_sda (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick),
        .a_in   (sda_a),
        .b_in   (sda_b),
        .a_low  (sda_a_low),
        .b_low  (sda_b_low)
    );

    assign esp_bus = {esp_dc, esp_sdi, esp_cs, esp_clk};
    assign {pnl_dc, pnl_sdi, pnl_cs, pnl_clk} = pnl_bus;

    eink_relay u_relay (
        .clk      (clk),
        .arst_n   (arst_n),
        .esp_bus  (esp_bus),
        .pnl_bus  (pnl_bus),
        .pnl_busy (pnl_busy),
        .esp_busy (esp_busy),
        .dc_q     (dc_q),
        .cs_q     (cs_q)
    );

    shutdown_fuze #(
        .FUZE_COUNT (FUZE_COUNT)
    ) u_fuze (
        .clk      (clk),
        .arst_n   (arst_n),
        .dc       (dc_q),
        .cs       (cs_q),
        .shutdown (shutdown)
    );

    // console straight through, no clocking
    assign esp_rxd  = host_txd;
    assign host_rxd = esp_txd;

endmodule

// ==== rtl/shutdown_fuze.sv ====
`timescale 1ns/1ns

module shutdown_fuze
    import panel_pkg::*;
#(
    parameter int FUZE_COUNT = 8 // dc falls needed to fire
)
(
    input  logic clk,
    input  logic arst_n,
    input  logic dc,        // registered dc from the relay
    input  logic cs,        // registered cs from the relay
    output logic shutdown   // power-off request, sticky
);

    localparam int CNT_W = $clog2(FUZE_COUNT + 1);

    fuze_state_t      state;
    logic             dc_prev;
    logic [CNT_W-1:0] fall_cnt;
    logic             dc_fall;

    assign dc_fall = dc_prev & ~dc;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= ARMED;
            dc_prev  <= 1'b0;
            fall_cnt <= '0;
        end
        else
        begin
            dc_prev <= dc;
            case (state)
                ARMED:
                begin
                    fall_cnt <= '0;
                    if (cs)
                        state <= COUNTING;
                end
                COUNTING:
                begin
                    if (!cs)
                    begin
                        state    <= ARMED;    // gesture broken, start over
                        fall_cnt <= '0;
                    end
                    else if (dc_fall)
                    begin
                        if (fall_cnt == CNT_W'(FUZE_COUNT - 1))
                            state <= FIRED;   // last fall seen
                        fall_cnt <= fall_cnt + 1'b1;
                    end
                end
                FIRED:
                begin
                    state <= FIRED;           // only reset leaves
                end
                default:
                begin
                    state <= ARMED;
                end
            endcase
        end
    end

    assign shutdown = (state == FIRED);

endmodule

// ==== rtl/eink_relay.sv ====
`timescale 1ns/1ns

module eink_relay
    import panel_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  spi_bus_t esp_bus,   // from esp32
    output spi_bus_t pnl_bus,   // to panel header
    input  logic     pnl_busy,  // from panel
    output logic     esp_busy,  // back to esp32
    output logic     dc_q,      // registered dc for the fuze
    output logic     cs_q       // registered cs for the fuze
);

    spi_bus_t bus_q;   // outward stage
    logic     busy_q;  // inward stage

    // single register stage each way
    // removes glitches from the long esp32 routing
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bus_q  <= '0;
            busy_q <= 1'b0;
        end
        else
        begin
            bus_q  <= esp_bus;
            busy_q <= pnl_busy;
        end
    end

    assign pnl_bus  = bus_q;
    assign esp_busy = busy_q;

    // same flops feed the fuze, no second copy
    assign dc_q = bus_q[SPI_DC];
    assign cs_q = bus_q[SPI_CS];

endmodule

// ==== rtl/i2c_line_bridge.sv ====
`timescale 1ns/1ns

module i2c_line_bridge
    import bridge_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic tick,    // sampling strobe
    input  logic a_in,    // esp32 side line level
    input  logic b_in,    // hdmi side line level
    output logic a_low,   // pull-low enable toward esp32
    output logic b_low    // pull-low enable toward hdmi
);

    sync_vec_t     a_sync;     // a_in synchronizer
    sync_vec_t     b_sync;     // b_in synchronizer
    line_pair_t    lvl;        // synchronized levels, both sides
    bridge_state_t state;
    bridge_state_t state_nxt;

    // 2-flop synchronizers
    // preset high so the lines read idle out of reset
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            a_sync <= '1;
            b_sync <= '1;
        end
        else
        begin
            a_sync <= {a_sync[0], a_in};
            b_sync <= {b_sync[0], b_in};
        end
    end

    assign lvl[SIDE_A] = a_sync[1];
    assign lvl[SIDE_B] = b_sync[1];

    // next state, only taken on tick
    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (!lvl[SIDE_A])
                    state_nxt = A_HOLDS;  // a wins when both low
                else if (!lvl[SIDE_B])
                    state_nxt = B_HOLDS;
            end
            A_HOLDS:
            begin
                // b reads low because of our own pull, watch a only
                if (lvl[SIDE_A])
                    state_nxt = RELEASE;
            end
            B_HOLDS:
            begin
                if (lvl[SIDE_B])          // mirror case, watch b only
                    state_nxt = RELEASE;
            end
            RELEASE:
            begin
                // line we drove is still rising through the sync
                // so skip this sample entirely
                state_nxt = IDLE;
            end
            default:
            begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= IDLE;
        else if (tick)
            state <= state_nxt;   // slow sampling rate
    end

    // enables decoded straight from state
    // so they only move on the cycle after a tick
    assign b_low = (state == A_HOLDS);
    assign a_low = (state == B_HOLDS);

endmodule

// ==== rtl/tick_gen.sv ====
`timescale 1ns/1ns

module tick_gen #(
    parameter int DIV_BITS = 3 // tick every 1 + 2**DIV_BITS clocks
)
(
    input  logic clk,
    input  logic arst_n,
    output logic tick     // one clock wide strobe
);

    logic [DIV_BITS:0] cnt; // one bit wider than the power of two

    // counts 0 .. 2**DIV_BITS, top bit set for a single cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            cnt <= '0;
        else if (cnt[DIV_BITS])
            cnt <= '0;              // wrap right after the tick
        else
            cnt <= cnt + 1'b1;
    end

    assign tick = cnt[DIV_BITS];

endmodule

// ==== rtl/panel_pkg.sv ====
package panel_pkg;

    // e-paper spi lines, msb first: dc, sdi, cs, clk
    typedef logic [3:0] spi_bus_t;

    localparam int SPI_DC  = 3;
    localparam int SPI_SDI = 2; // only relayed, never decoded
    localparam int SPI_CS  = 1;
    localparam int SPI_CLK = 0; // only relayed, never decoded

    // power-off fuze FSM
    typedef enum logic [1:0] {
        ARMED    = 2'd0, // waiting for cs high
        COUNTING = 2'd1, // cs high, dc falls counted
        FIRED    = 2'd2  // latched until reset
    } fuze_state_t;

endpackage

// ==== rtl/bridge_pkg.sv ====
package bridge_pkg;

    // one line level per side
    // bit 0 is the esp32 side, bit 1 the hdmi ddc side
    typedef logic [1:0] line_pair_t;

    localparam int SIDE_A = 0; // esp32
    localparam int SIDE_B = 1; // hdmi

    // stages of one input synchronizer, [0] first flop
    typedef logic [1:0] sync_vec_t;

    // release guard FSM of one open-drain line
    typedef enum logic [1:0] {
        IDLE    = 2'd0, // nobody pulls low
        A_HOLDS = 2'd1, // a low, we pull b
        B_HOLDS = 2'd2, // b low, we pull a
        RELEASE = 2'd3  // one tick guard after letting go
    } bridge_state_t;

endpackage
